/* rtl/issue_pkg.sv */
package issue_pkg;

    // Physical register file size, one complete_list bit per register
    localparam int PHYS_REGS = 32;

    typedef logic [4:0]  phys_tag_t;
    typedef logic [31:0] data_t;

    // Functional unit class of an entry
    typedef enum logic {
        FU_ALU  = 1'b0,
        FU_MULT = 1'b1
    } fu_type_e;

    // One reservation station entry as seen by issue
    typedef struct packed {
        fu_type_e  fu_type;
        phys_tag_t src1_tag;
        logic      src1_ready;
        phys_tag_t src2_tag;
        logic      src2_ready;
        phys_tag_t dest_tag;
        logic [3:0] func;
        data_t     pc;
    } rs_entry_t;

    // One forwarded CDB slot
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
        data_t     data;
    } cdb_fwd_t;

    // Request from select to one issue lane
    typedef struct packed {
        logic      valid;
        rs_entry_t entry;
    } lane_req_t;

    // Registered packet sent to a functional unit
    typedef struct packed {
        logic       valid;
        fu_type_e   fu_type;
        logic [3:0] func;
        data_t      pc;
        phys_tag_t  dest_tag;
        data_t      opa;
        data_t      opb;
    } issue_packet_t;

endpackage

/* rtl/priority_picker.sv */
`timescale 1ns/1ps

module priority_picker #(
    parameter int WIDTH = 8,
    parameter int REQS  = 2
) (
    input  logic [WIDTH-1:0]            req,
    output logic [REQS-1:0][WIDTH-1:0]  gnt_bus,
    output logic [WIDTH-1:0]            gnt
);

    logic [WIDTH-1:0] remaining;

    // Grant k takes the lowest request still left after grants 0..k-1
    always_comb begin
        remaining = req;
        gnt_bus   = '0;
        gnt       = '0;
        for (int k = 0; k < REQS; k++) begin
            // Isolate the lowest set bit
            gnt_bus[k] = remaining & (~remaining + 1'b1);
            remaining  = remaining & ~gnt_bus[k];
            gnt        = gnt | gnt_bus[k];
        end
    end

endmodule

/* rtl/issue_select.sv */
`timescale 1ns/1ps

module issue_select import issue_pkg::*; #(
    parameter int RS_SIZE   = 8,
    parameter int NUM_ALU   = 2,
    parameter int NUM_MULT  = 2,
    parameter int CDB_WIDTH = 2
) (
    input  rs_entry_t [RS_SIZE-1:0]           rs_entries,
    input  logic [RS_SIZE-1:0]                rs_valid,
    input  logic [NUM_MULT-1:0]               mult_free,
    input  logic [NUM_MULT-1:0]               mult_cdb_req,
    output lane_req_t [NUM_ALU+NUM_MULT-1:0]  lane_reqs,
    output logic [NUM_ALU-1:0]                alu_issue_gnt,
    output logic [NUM_MULT-1:0]               mult_cdb_gnt,
    output logic [RS_SIZE-1:0]                rs_issuing
);

    logic [RS_SIZE-1:0]                alu_ready;
    logic [RS_SIZE-1:0]                mult_ready;
    logic [NUM_ALU-1:0][RS_SIZE-1:0]   alu_pick_bus;
    logic [NUM_MULT-1:0][RS_SIZE-1:0]  mult_pick_bus;
    logic [NUM_ALU-1:0]                alu_cand;
    logic [NUM_MULT-1:0]               mult_issue;
    logic [NUM_ALU+NUM_MULT-1:0]       cdb_gnt;

    // Ready means valid with both sources available
    always_comb begin
        for (int i = 0; i < RS_SIZE; i++) begin
            alu_ready[i]  = rs_valid[i] && rs_entries[i].src1_ready &&
                            rs_entries[i].src2_ready && (rs_entries[i].fu_type == FU_ALU);
            mult_ready[i] = rs_valid[i] && rs_entries[i].src1_ready &&
                            rs_entries[i].src2_ready && (rs_entries[i].fu_type == FU_MULT);
        end
    end

    priority_picker #(.WIDTH(RS_SIZE), .REQS(NUM_ALU)) alu_picker (
        .req     (alu_ready),
        .gnt_bus (alu_pick_bus),
        .gnt     ()
    );

    priority_picker #(.WIDTH(RS_SIZE), .REQS(NUM_MULT)) mult_picker (
        .req     (mult_ready),
        .gnt_bus (mult_pick_bus),
        .gnt     ()
    );

    // Multiplier completions sit in the low bits, so they win the CDB
    priority_picker #(.WIDTH(NUM_ALU+NUM_MULT), .REQS(CDB_WIDTH)) cdb_picker (
        .req     ({alu_cand, mult_cdb_req}),
        .gnt_bus (),
        .gnt     (cdb_gnt)
    );

    assign mult_cdb_gnt  = cdb_gnt[NUM_MULT-1:0];
    assign alu_issue_gnt = cdb_gnt[NUM_ALU+NUM_MULT-1:NUM_MULT];

    always_comb begin
        rs_issuing = '0;
        for (int j = 0; j < NUM_ALU; j++) begin
            alu_cand[j] = |alu_pick_bus[j];
            lane_reqs[j].valid = alu_issue_gnt[j];
            lane_reqs[j].entry = '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                if (alu_pick_bus[j][i]) lane_reqs[j].entry = rs_entries[i];
            end
            if (alu_issue_gnt[j]) rs_issuing = rs_issuing | alu_pick_bus[j];
        end
        // Mult pick k is tied to unit k and waits while that unit is busy
        for (int k = 0; k < NUM_MULT; k++) begin
            mult_issue[k] = (|mult_pick_bus[k]) && mult_free[k];
            lane_reqs[NUM_ALU+k].valid = mult_issue[k];
            lane_reqs[NUM_ALU+k].entry = '0;
            for (int i = 0; i < RS_SIZE; i++) begin
                if (mult_pick_bus[k][i]) lane_reqs[NUM_ALU+k].entry = rs_entries[i];
            end
            if (mult_issue[k]) rs_issuing = rs_issuing | mult_pick_bus[k];
        end
    end

endmodule

/* rtl/issue_lane.sv */
`timescale 1ns/1ps

module issue_lane import issue_pkg::*; #(
    parameter int CDB_WIDTH = 2
) (
    input  logic                      clock,
    input  logic                      reset,
    input  lane_req_t                 lane_req,
    input  logic [PHYS_REGS-1:0]      complete_list,
    input  cdb_fwd_t [CDB_WIDTH-1:0]  cdb_fwd,
    input  data_t                     rf_data_1,
    input  data_t                     rf_data_2,
    output phys_tag_t                 rf_tag_1,
    output phys_tag_t                 rf_tag_2,
    output issue_packet_t             packet
);

    issue_packet_t next_packet;

    // Register file if completed, else the lowest matching CDB slot
    function automatic data_t pick_operand(input phys_tag_t tag, input data_t rf_data);
        data_t result;
        result = '0;
        if (complete_list[tag]) begin
            result = rf_data;
        end else begin
            // Scan downwards so the lowest matching slot is the one kept
            for (int s = CDB_WIDTH - 1; s >= 0; s--) begin
                if (cdb_fwd[s].valid && (cdb_fwd[s].tag == tag)) result = cdb_fwd[s].data;
            end
        end
        return result;
    endfunction

    assign rf_tag_1 = lane_req.entry.src1_tag;
    assign rf_tag_2 = lane_req.entry.src2_tag;

    always_comb begin
        next_packet.valid    = lane_req.valid;
        next_packet.fu_type  = lane_req.entry.fu_type;
        next_packet.func     = lane_req.entry.func;
        next_packet.pc       = lane_req.entry.pc;
        next_packet.dest_tag = lane_req.entry.dest_tag;
        next_packet.opa      = pick_operand(lane_req.entry.src1_tag, rf_data_1);
        next_packet.opb      = pick_operand(lane_req.entry.src2_tag, rf_data_2);
    end

    // Reset clears the valid bit
    always_ff @(posedge clock) begin
        packet <= next_packet;
        if (reset) begin
            packet.valid <= 1'b0;
        end
    end

endmodule

/* rtl/issue_collect.sv */
`timescale 1ns/1ps

module issue_collect import issue_pkg::*; #(
    parameter int NUM_ALU   = 2,
    parameter int NUM_MULT  = 2,
    parameter int CDB_WIDTH = 2
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  issue_packet_t [NUM_ALU+NUM_MULT-1:0]        lane_packets,
    input  logic [NUM_ALU-1:0]                          alu_issue_gnt,
    input  logic [NUM_MULT-1:0]                         mult_cdb_gnt,
    output issue_packet_t [NUM_ALU-1:0]                 alu_packets,
    output issue_packet_t [NUM_MULT-1:0]                mult_packets,
    output logic [CDB_WIDTH-1:0][NUM_ALU+NUM_MULT-1:0]  complete_gnt_bus
);

    localparam int NUM_LANES = NUM_ALU + NUM_MULT;

    logic [CDB_WIDTH-1:0][NUM_LANES-1:0] next_gnt_bus;

    // Lanes are ordered ALU first, then multiplier unit k on lane NUM_ALU+k
    assign alu_packets  = lane_packets[NUM_ALU-1:0];
    assign mult_packets = lane_packets[NUM_LANES-1:NUM_ALU];

    // At most CDB_WIDTH grants are set, so this only sorts them into slots
    priority_picker #(.WIDTH(NUM_LANES), .REQS(CDB_WIDTH)) slot_picker (
        .req     ({mult_cdb_gnt, alu_issue_gnt}),
        .gnt_bus (next_gnt_bus),
        .gnt     ()
    );

    always_ff @(posedge clock) begin
        if (reset) begin
            complete_gnt_bus <= '0;
        end else begin
            complete_gnt_bus <= next_gnt_bus;
        end
    end

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage import issue_pkg::*; #(
    parameter int RS_SIZE   = 8,
    parameter int NUM_ALU   = 2,
    parameter int NUM_MULT  = 2,
    parameter int CDB_WIDTH = 2
) (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rs_entry_t [RS_SIZE-1:0]                     rs_entries,
    input  logic [RS_SIZE-1:0]                          rs_valid,
    input  logic [PHYS_REGS-1:0]                        complete_list,
    input  cdb_fwd_t [CDB_WIDTH-1:0]                    cdb_fwd,
    input  logic [NUM_MULT-1:0]                         mult_free,
    input  logic [NUM_MULT-1:0]                         mult_cdb_req,
    input  data_t [NUM_ALU+NUM_MULT-1:0]                rf_data_1,
    input  data_t [NUM_ALU+NUM_MULT-1:0]                rf_data_2,
    output logic [RS_SIZE-1:0]                          rs_issuing,
    output phys_tag_t [NUM_ALU+NUM_MULT-1:0]            rf_tag_1,
    output phys_tag_t [NUM_ALU+NUM_MULT-1:0]            rf_tag_2,
    output issue_packet_t [NUM_ALU-1:0]                 alu_packets,
    output issue_packet_t [NUM_MULT-1:0]                mult_packets,
    output logic [NUM_MULT-1:0]                         mult_cdb_gnt,
    output logic [CDB_WIDTH-1:0][NUM_ALU+NUM_MULT-1:0]  complete_gnt_bus
);

    localparam int NUM_LANES = NUM_ALU + NUM_MULT;

    lane_req_t [NUM_LANES-1:0]     lane_reqs;
    issue_packet_t [NUM_LANES-1:0] lane_packets;
    logic [NUM_ALU-1:0]            alu_issue_gnt;

    issue_select #(
        .RS_SIZE   (RS_SIZE),
        .NUM_ALU   (NUM_ALU),
        .NUM_MULT  (NUM_MULT),
        .CDB_WIDTH (CDB_WIDTH)
    ) select (
        .rs_entries    (rs_entries),
        .rs_valid      (rs_valid),
        .mult_free     (mult_free),
        .mult_cdb_req  (mult_cdb_req),
        .lane_reqs     (lane_reqs),
        .alu_issue_gnt (alu_issue_gnt),
        .mult_cdb_gnt  (mult_cdb_gnt),
        .rs_issuing    (rs_issuing)
    );

    // One lane per ALU and per multiplier unit
    for (genvar l = 0; l < NUM_LANES; l++) begin : gen_lane
        issue_lane #(.CDB_WIDTH(CDB_WIDTH)) lane (
            .clock         (clock),
            .reset         (reset),
            .lane_req      (lane_reqs[l]),
            .complete_list (complete_list),
            .cdb_fwd       (cdb_fwd),
            .rf_data_1     (rf_data_1[l]),
            .rf_data_2     (rf_data_2[l]),
            .rf_tag_1      (rf_tag_1[l]),
            .rf_tag_2      (rf_tag_2[l]),
            .packet        (lane_packets[l])
        );
    end

    issue_collect #(
        .NUM_ALU   (NUM_ALU),
        .NUM_MULT  (NUM_MULT),
        .CDB_WIDTH (CDB_WIDTH)
    ) collect (
        .clock            (clock),
        .reset            (reset),
        .lane_packets     (lane_packets),
        .alu_issue_gnt    (alu_issue_gnt),
        .mult_cdb_gnt     (mult_cdb_gnt),
        .alu_packets      (alu_packets),
        .mult_packets     (mult_packets),
        .complete_gnt_bus (complete_gnt_bus)
    );

endmodule

/* verification/issue_model.svh */
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// 32-bit xorshift, state kept in rng_state
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

// Completed registers come from the file, others from the lowest matching CDB slot
function automatic data_t expect_operand(input phys_tag_t tag);
    if (complete_list[tag]) begin
        return rf_model[tag];
    end
    for (int s = 0; s < CDB_WIDTH; s++) begin
        if (cdb_fwd[s].valid && (cdb_fwd[s].tag == tag)) begin
            return cdb_fwd[s].data;
        end
    end
    return '0;
endfunction

function automatic issue_packet_t expect_packet(input int idx);
    issue_packet_t p;
    p.valid    = 1'b1;
    p.fu_type  = rs_entries[idx].fu_type;
    p.func     = rs_entries[idx].func;
    p.pc       = rs_entries[idx].pc;
    p.dest_tag = rs_entries[idx].dest_tag;
    p.opa      = expect_operand(rs_entries[idx].src1_tag);
    p.opb      = expect_operand(rs_entries[idx].src2_tag);
    return p;
endfunction

// Same-cycle grants, plus the packets and slot bus due at the next edge
function automatic void run_model();
    int alu_idx[$];
    int mult_idx[$];
    int used;
    int slot;
    logic [NUM_LANES-1:0] unit_gnt;
    exp_issuing  = '0;
    exp_cdb_gnt  = '0;
    exp_tag_1    = '0;
    exp_tag_2    = '0;
    next_pkt     = '0;
    next_gnt_bus = '0;
    unit_gnt     = '0;
    used         = 0;
    slot         = 0;
    for (int i = 0; i < RS_SIZE; i++) begin
        if (rs_valid[i] && rs_entries[i].src1_ready && rs_entries[i].src2_ready) begin
            if (rs_entries[i].fu_type == FU_ALU) begin
                alu_idx.push_back(i);
            end else begin
                mult_idx.push_back(i);
            end
        end
    end
    // Waiting multiplier results claim CDB slots before new ALU work
    for (int k = 0; k < NUM_MULT; k++) begin
        if (mult_cdb_req[k] && (used < CDB_WIDTH)) begin
            exp_cdb_gnt[k]      = 1'b1;
            unit_gnt[NUM_ALU+k] = 1'b1;
            used++;
        end
    end
    for (int j = 0; (j < NUM_ALU) && (j < alu_idx.size()); j++) begin
        if (used < CDB_WIDTH) begin
            exp_issuing[alu_idx[j]] = 1'b1;
            unit_gnt[j]             = 1'b1;
            next_pkt[j]             = expect_packet(alu_idx[j]);
            exp_tag_1[j]            = rs_entries[alu_idx[j]].src1_tag;
            exp_tag_2[j]            = rs_entries[alu_idx[j]].src2_tag;
            used++;
        end
    end
    // Pick k only goes to unit k
    for (int k = 0; (k < NUM_MULT) && (k < mult_idx.size()); k++) begin
        if (mult_free[k]) begin
            exp_issuing[mult_idx[k]] = 1'b1;
            next_pkt[NUM_ALU+k]      = expect_packet(mult_idx[k]);
            exp_tag_1[NUM_ALU+k]     = rs_entries[mult_idx[k]].src1_tag;
            exp_tag_2[NUM_ALU+k]     = rs_entries[mult_idx[k]].src2_tag;
        end
    end
    // Slots fill in ascending unit order
    for (int u = 0; u < NUM_LANES; u++) begin
        if (unit_gnt[u] && (slot < CDB_WIDTH)) begin
            next_gnt_bus[slot][u] = 1'b1;
            slot++;
        end
    end
endfunction

`endif

/* verification/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb import issue_pkg::*; ();

    localparam int RS_SIZE    = 8;
    localparam int NUM_ALU    = 2;
    localparam int NUM_MULT   = 2;
    localparam int CDB_WIDTH  = 2;
    localparam int NUM_LANES  = NUM_ALU + NUM_MULT;
    localparam logic [31:0] SEED = 32'h9b88;
    localparam int NUM_CYCLES = 400;
    localparam int WAIT_LIMIT = 20;

    logic clock = 1'b0;
    logic reset;
    rs_entry_t [RS_SIZE-1:0]             rs_entries;
    logic [RS_SIZE-1:0]                  rs_valid;
    logic [PHYS_REGS-1:0]                complete_list;
    cdb_fwd_t [CDB_WIDTH-1:0]            cdb_fwd;
    logic [NUM_MULT-1:0]                 mult_free;
    logic [NUM_MULT-1:0]                 mult_cdb_req;
    data_t [NUM_LANES-1:0]               rf_data_1;
    data_t [NUM_LANES-1:0]               rf_data_2;
    logic [RS_SIZE-1:0]                  rs_issuing;
    phys_tag_t [NUM_LANES-1:0]           rf_tag_1;
    phys_tag_t [NUM_LANES-1:0]           rf_tag_2;
    issue_packet_t [NUM_ALU-1:0]         alu_packets;
    issue_packet_t [NUM_MULT-1:0]        mult_packets;
    logic [NUM_MULT-1:0]                 mult_cdb_gnt;
    logic [CDB_WIDTH-1:0][NUM_LANES-1:0] complete_gnt_bus;

    data_t                               rf_model [PHYS_REGS];
    logic [31:0]                         rng_state;
    logic [RS_SIZE-1:0]                  exp_issuing;
    logic [NUM_MULT-1:0]                 exp_cdb_gnt;
    phys_tag_t [NUM_LANES-1:0]           exp_tag_1;
    phys_tag_t [NUM_LANES-1:0]           exp_tag_2;
    issue_packet_t [NUM_LANES-1:0]       next_pkt;
    issue_packet_t [NUM_LANES-1:0]       held_pkt;
    logic [CDB_WIDTH-1:0][NUM_LANES-1:0] next_gnt_bus;
    logic [CDB_WIDTH-1:0][NUM_LANES-1:0] held_gnt_bus;
    int errors;
    int checks;
    int tests;

    `include "issue_model.svh"

    issue_stage #(
        .RS_SIZE   (RS_SIZE),
        .NUM_ALU   (NUM_ALU),
        .NUM_MULT  (NUM_MULT),
        .CDB_WIDTH (CDB_WIDTH)
    ) uut (.*);

    always #5 clock = ~clock;

    // Register file answers the read tags without delay
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rf_data_1[l] = rf_model[rf_tag_1[l]];
            rf_data_2[l] = rf_model[rf_tag_2[l]];
        end
    end

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: got %0h expected %0h", name, got, exp);
        end
    endtask

    task automatic check_idle();
        for (int l = 0; l < NUM_ALU; l++) begin
            check_value($sformatf("alu_packets[%0d].valid", l), alu_packets[l].valid, 1'b0);
        end
        for (int k = 0; k < NUM_MULT; k++) begin
            check_value($sformatf("mult_packets[%0d].valid", k), mult_packets[k].valid, 1'b0);
        end
        check_value("complete_gnt_bus", complete_gnt_bus, '0);
    endtask

    task automatic drive_stimulus(input logic busy, input logic all_req);
        rs_entry_t [RS_SIZE-1:0]  ent;
        cdb_fwd_t [CDB_WIDTH-1:0] fwd;
        logic [PHYS_REGS-1:0]     done;
        logic [31:0]              r;
        int s1;
        int s2;
        done = next_rand();
        for (int s = 0; s < CDB_WIDTH; s++) begin
            r = next_rand();
            fwd[s].valid = (r[1:0] != 2'b00);
            fwd[s].tag   = r[6:2];
            fwd[s].data  = next_rand();
            // A tag still on the CDB is not complete yet
            if (fwd[s].valid) done[fwd[s].tag] = 1'b0;
        end
        for (int i = 0; i < RS_SIZE; i++) begin
            r = next_rand();
            ent[i].fu_type    = fu_type_e'(r[0]);
            ent[i].src1_ready = r[1] | r[2];
            ent[i].src2_ready = r[3] | r[4];
            ent[i].src1_tag   = r[9:5];
            ent[i].src2_tag   = r[14:10];
            ent[i].dest_tag   = r[19:15];
            ent[i].func       = r[23:20];
            ent[i].pc         = next_rand();
            s1 = r[25:24] % CDB_WIDTH;
            s2 = r[27:26] % CDB_WIDTH;
            // Ready sources are either forwarded this cycle or complete
            if (r[28] && fwd[s1].valid) begin
                ent[i].src1_tag = fwd[s1].tag;
            end else if (ent[i].src1_ready) begin
                done[ent[i].src1_tag] = 1'b1;
            end
            if (r[29] && fwd[s2].valid) begin
                ent[i].src2_tag = fwd[s2].tag;
            end else if (ent[i].src2_ready) begin
                done[ent[i].src2_tag] = 1'b1;
            end
        end
        r = next_rand();
        rs_entries    <= ent;
        rs_valid      <= r[0 +: RS_SIZE] | r[8 +: RS_SIZE];
        complete_list <= done;
        cdb_fwd       <= fwd;
        mult_free     <= busy ? '0 : r[20 +: NUM_MULT];
        mult_cdb_req  <= all_req ? '1 : (r[24 +: NUM_MULT] & r[26 +: NUM_MULT]);
    endtask

    // Registered outputs against last cycle's model, then this cycle's grants
    task automatic check_outputs();
        issue_packet_t [NUM_LANES-1:0] lanes;
        string name;
        lanes = {mult_packets, alu_packets};
        for (int l = 0; l < NUM_LANES; l++) begin
            name = (l < NUM_ALU) ? $sformatf("alu_packets[%0d]", l) :
                                   $sformatf("mult_packets[%0d]", l - NUM_ALU);
            if (held_pkt[l].valid) begin
                check_value(name, lanes[l], held_pkt[l]);
            end else begin
                check_value({name, ".valid"}, lanes[l].valid, 1'b0);
            end
        end
        check_value("complete_gnt_bus", complete_gnt_bus, held_gnt_bus);
        run_model();
        check_value("rs_issuing", rs_issuing, exp_issuing);
        check_value("mult_cdb_gnt", mult_cdb_gnt, exp_cdb_gnt);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (next_pkt[l].valid) begin
                check_value($sformatf("rf_tag_1[%0d]", l), rf_tag_1[l], exp_tag_1[l]);
                check_value($sformatf("rf_tag_2[%0d]", l), rf_tag_2[l], exp_tag_2[l]);
            end
        end
        held_pkt     = next_pkt;
        held_gnt_bus = next_gnt_bus;
    endtask

    task automatic run_cycle(input logic busy, input logic all_req);
        @(posedge clock);
        drive_stimulus(busy, all_req);
        @(negedge clock);
        check_outputs();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        $display("%s: %s", name, (errors == errors_before) ? "passed" : "failed");
    endtask

    initial begin
        int base;
        int waited;
        rng_state     = SEED;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        reset         = 1'b1;
        rs_entries    = '0;
        rs_valid      = '0;
        complete_list = '0;
        cdb_fwd       = '0;
        mult_free     = '0;
        mult_cdb_req  = '0;
        held_pkt      = '0;
        held_gnt_bus  = '0;
        for (int a = 0; a < PHYS_REGS; a++) begin
            rf_model[a] = next_rand();
        end
        base = errors;

        // Busy inputs during reset, idle again before the first edge out of reset
        @(posedge clock);
        drive_stimulus(1'b0, 1'b1);
        @(posedge clock);
        reset        <= 1'b0;
        rs_valid     <= '0;
        mult_cdb_req <= '0;
        @(negedge clock);
        check_idle();

        // Idle outputs until the first issue or CDB grant
        waited = 0;
        do begin
            run_cycle(1'b0, 1'b0);
            check_idle();
            waited++;
        end while ((rs_issuing == '0) && (mult_cdb_gnt == '0) && (waited < WAIT_LIMIT));
        if ((rs_issuing == '0) && (mult_cdb_gnt == '0)) begin
            errors++;
            $display("no issue or CDB grant within %0d cycles after reset", WAIT_LIMIT);
        end
        finish_test("reset and first issue", base);

        base = errors;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            run_cycle(1'b0, 1'b0);
        end
        finish_test("random issue", base);

        // All multiplier units busy
        base = errors;
        for (int c = 0; c < 60; c++) begin
            run_cycle(1'b1, 1'b0);
        end
        finish_test("multiplier back-pressure", base);

        // Every unit wants the CDB, so no ALU work may issue
        base = errors;
        for (int c = 0; c < 60; c++) begin
            run_cycle(1'b0, 1'b1);
        end
        run_cycle(1'b0, 1'b0);
        finish_test("CDB arbitration", base);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verification
rtl/issue_pkg.sv
rtl/priority_picker.sv
rtl/issue_select.sv
rtl/issue_lane.sv
rtl/issue_collect.sv
rtl/issue_stage.sv
verification/issue_tb.sv
